//--- verilog/aib_adapt_pkg.sv
// ==============================
// aib adapter shared definitions
// ==============================
`default_nettype none

package aib_adapt_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int BEAT_W    = 40;
  localparam int PAYLOAD_W = 39;
  localparam int WORD_W    = 78;
  localparam int SB_LEN    = 81;
  localparam int SB_CNT_W  = $clog2(SB_LEN);
  localparam int DLY_MAX   = 7;
  localparam int DLY_W     = $clog2(DLY_MAX + 1);
  localparam int CFG_AW    = 3;
  localparam int CFG_DW    = 32;
  localparam int SB_HI_W   = SB_LEN - 2 * CFG_DW; // upper sideband slice, 17 bits

  // ==============================
  // register map
  // ==============================
  localparam logic [CFG_AW-1:0] REG_RX_CTRL = 3'd0; // wa_en, rx_dly
  localparam logic [CFG_AW-1:0] REG_TX_CTRL = 3'd1; // lpbk_en, tx_dly
  localparam logic [CFG_AW-1:0] REG_SB_TX0  = 3'd2;
  localparam logic [CFG_AW-1:0] REG_SB_TX1  = 3'd3;
  localparam logic [CFG_AW-1:0] REG_SB_TX2  = 3'd4;
  localparam logic [CFG_AW-1:0] REG_SB_RX0  = 3'd5;
  localparam logic [CFG_AW-1:0] REG_SB_RX1  = 3'd6;
  localparam logic [CFG_AW-1:0] REG_SB_RX2  = 3'd7;

  localparam int SB_TX_EN_BIT = 78; // far side tx transfer enable
  localparam int SB_RX_EN_BIT = 75;

  typedef struct packed {
    logic                 marker;  // 1 on first beat of a word
    logic [PAYLOAD_W-1:0] payload;
  } beat_t;

  typedef struct packed {
    logic             wa_en;
    logic [DLY_W-1:0] rx_dly;
    logic             lpbk_en;
    logic [DLY_W-1:0] tx_dly;
  } adapt_cfg_t;

  typedef struct packed {
    logic              read;
    logic              write;
    logic [CFG_AW-1:0] addr;
    logic [CFG_DW-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [CFG_DW-1:0] rdata;
    logic              rdatavld;
    logic              waitreq;
  } cfg_rsp_t;

endpackage

`default_nettype wire

//--- verilog/aib_adapt_phcomp_dly.sv
// ==============================
// phase comp delay line
// ==============================
`default_nettype none

module aib_adapt_phcomp_dly #(
  parameter type payload_t = logic [aib_adapt_pkg::BEAT_W-1:0]
) (
  input  wire                             fs_fwd_clk,
  input  wire                             adpt_rstn_sync_fsfwdclk,
  input  wire [aib_adapt_pkg::DLY_W-1:0]  i_dly,
  input  wire                             i_vld,
  input  wire payload_t                   i_data,
  output logic                            o_vld,
  output payload_t                        o_data
);
  import aib_adapt_pkg::*;

  logic [DLY_MAX:0] vld_q;
  payload_t         dat_q [DLY_MAX+1];

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
      vld_q <= '0;
    else
      vld_q <= {vld_q[DLY_MAX-1:0], i_vld};
  end

  always_ff @(posedge fs_fwd_clk)
  begin
    dat_q[0] <= i_data;
    for (int k = 1; k <= DLY_MAX; k++)
      dat_q[k] <= dat_q[k-1];
  end

  assign o_vld  = vld_q[i_dly];  // tap 0 is one cycle
  assign o_data = dat_q[i_dly];

endmodule

`default_nettype wire

//--- verilog/aib_adapt_csr.sv
// ==============================
// adapter config registers
// ==============================
`default_nettype none

module aib_adapt_csr (
  input  wire                               fs_fwd_clk,
  input  wire                               adpt_rstn_sync_fsfwdclk,
  input  wire aib_adapt_pkg::cfg_req_t      i_cfg_req,
  output aib_adapt_pkg::cfg_rsp_t           o_cfg_rsp,
  output aib_adapt_pkg::adapt_cfg_t         o_cfg,
  output logic [aib_adapt_pkg::SB_LEN-1:0]  o_sb_tx_word,
  input  wire  [aib_adapt_pkg::SB_LEN-1:0]  i_sb_rx_word
);
  import aib_adapt_pkg::*;

  logic              req;
  logic              accept;
  logic              ack_q;       // the one cycle with waitreq low
  logic              rdatavld_q;
  logic [DLY_W:0]    rx_ctrl_q;
  logic [DLY_W:0]    tx_ctrl_q;
  logic [CFG_DW-1:0] sb_tx0_q;
  logic [CFG_DW-1:0] sb_tx1_q;
  logic [SB_HI_W-1:0] sb_tx2_q;
  logic [CFG_DW-1:0] rd_mux;
  logic [CFG_DW-1:0] rdata_q;

  assign req    = i_cfg_req.read | i_cfg_req.write;
  assign accept = ack_q & req;

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      ack_q      <= 1'b0;
      rdatavld_q <= 1'b0;
      rx_ctrl_q  <= '0;
      tx_ctrl_q  <= '0;
      sb_tx0_q   <= '0;
      sb_tx1_q   <= '0;
      sb_tx2_q   <= '0;
    end
    else
    begin
      ack_q      <= req & ~ack_q;
      rdatavld_q <= accept & i_cfg_req.read;
      if (accept && i_cfg_req.write)
      begin
        case (i_cfg_req.addr)
          REG_RX_CTRL: rx_ctrl_q <= i_cfg_req.wdata[DLY_W:0];
          REG_TX_CTRL: tx_ctrl_q <= i_cfg_req.wdata[DLY_W:0];
          REG_SB_TX0:  sb_tx0_q  <= i_cfg_req.wdata;
          REG_SB_TX1:  sb_tx1_q  <= i_cfg_req.wdata;
          REG_SB_TX2:  sb_tx2_q  <= i_cfg_req.wdata[SB_HI_W-1:0];
          default:     ;  // rx sideband is read only
        endcase
      end
    end
  end

  always_comb
  begin
    rd_mux = '0;
    case (i_cfg_req.addr)
      REG_RX_CTRL: rd_mux[DLY_W:0]   = rx_ctrl_q;
      REG_TX_CTRL: rd_mux[DLY_W:0]   = tx_ctrl_q;
      REG_SB_TX0:  rd_mux            = sb_tx0_q;
      REG_SB_TX1:  rd_mux            = sb_tx1_q;
      REG_SB_TX2:  rd_mux[SB_HI_W-1:0] = sb_tx2_q;
      REG_SB_RX0:  rd_mux            = i_sb_rx_word[CFG_DW-1:0];
      REG_SB_RX1:  rd_mux            = i_sb_rx_word[2*CFG_DW-1:CFG_DW];
      REG_SB_RX2:  rd_mux[SB_HI_W-1:0] = i_sb_rx_word[SB_LEN-1:2*CFG_DW];
      default:     rd_mux            = '0;
    endcase
  end

  always_ff @(posedge fs_fwd_clk)
  begin
    if (accept)
      rdata_q <= rd_mux;
  end

  assign o_cfg_rsp.rdata    = rdata_q;
  assign o_cfg_rsp.rdatavld = rdatavld_q;
  assign o_cfg_rsp.waitreq  = ~ack_q;  // high while idle

  assign o_cfg.wa_en   = rx_ctrl_q[0];
  assign o_cfg.rx_dly  = rx_ctrl_q[DLY_W:1];
  assign o_cfg.lpbk_en = tx_ctrl_q[0];
  assign o_cfg.tx_dly  = tx_ctrl_q[DLY_W:1];
  assign o_sb_tx_word  = {sb_tx2_q, sb_tx1_q, sb_tx0_q};

endmodule

`default_nettype wire

//--- verilog/aib_adapt_txchnl.sv
// ==============================
// adapter transmit channel
// ==============================
`default_nettype none

module aib_adapt_txchnl (
  input  wire                              fs_fwd_clk,
  input  wire                              adpt_rstn_sync_fsfwdclk,
  input  wire aib_adapt_pkg::adapt_cfg_t   i_cfg,
  input  wire  [aib_adapt_pkg::WORD_W-1:0] i_data_in,
  input  wire                              i_tx_valid,
  output logic                             o_tx_ready,
  input  wire  [aib_adapt_pkg::BEAT_W-1:0] i_din,
  output logic [aib_adapt_pkg::BEAT_W-1:0] o_dout
);
  import aib_adapt_pkg::*;

  typedef enum logic {ST_FREE, ST_LOW} seq_t;

  seq_t              state_q;     // ST_LOW while the first beat is out
  logic              hi_vld_q;    // second beat out this cycle
  logic [WORD_W-1:0] word_q;
  beat_t             seq_beat;
  logic              seq_vld;
  beat_t             dly_beat;
  logic              dly_vld;
  beat_t             out_beat;
  logic              out_vld;

  // ready only with a word pending, so it doubles as accept
  assign o_tx_ready = i_tx_valid & ~i_cfg.lpbk_en & (state_q == ST_FREE);

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      state_q  <= ST_FREE;
      hi_vld_q <= 1'b0;
    end
    else
    begin
      state_q  <= o_tx_ready ? ST_LOW : ST_FREE;
      hi_vld_q <= (state_q == ST_LOW);
    end
  end

  always_ff @(posedge fs_fwd_clk)
  begin
    if (o_tx_ready)
      word_q <= i_data_in;
  end

  always_comb
  begin
    seq_beat.marker  = (state_q == ST_LOW);
    seq_beat.payload = (state_q == ST_LOW) ? word_q[PAYLOAD_W-1:0]
                                           : word_q[WORD_W-1:PAYLOAD_W];
  end
  assign seq_vld = (state_q == ST_LOW) | hi_vld_q;

  // loopback takes every rx beat
  assign dly_beat = i_cfg.lpbk_en ? beat_t'(i_din) : seq_beat;
  assign dly_vld  = i_cfg.lpbk_en | seq_vld;

  aib_adapt_phcomp_dly #(.payload_t(beat_t)) u_tx_dly (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_dly                   (i_cfg.tx_dly),
    .i_vld                   (dly_vld),
    .i_data                  (dly_beat),
    .o_vld                   (out_vld),
    .o_data                  (out_beat)
  );

  assign o_dout = out_vld ? out_beat : '0;  // idle beats are zero

endmodule

`default_nettype wire

//--- verilog/aib_adapt_rxchnl.sv
// ==============================
// adapter receive channel
// ==============================
`default_nettype none

module aib_adapt_rxchnl (
  input  wire                              fs_fwd_clk,
  input  wire                              adpt_rstn_sync_fsfwdclk,
  input  wire aib_adapt_pkg::adapt_cfg_t   i_cfg,
  input  wire  [aib_adapt_pkg::BEAT_W-1:0] i_din,
  output wire  [aib_adapt_pkg::WORD_W-1:0] o_data_out,
  output wire                              o_rx_valid,
  output logic                             o_align_done
);
  import aib_adapt_pkg::*;

  beat_t                din_beat;
  logic                 have_first_q;  // first beat of a pair is held
  logic [PAYLOAD_W-1:0] first_pld_q;
  logic                 first_mrk_q;   // marker of the held beat
  logic                 pair_ok;
  logic                 start_ok;
  logic                 align_q;
  logic [WORD_W-1:0]    word;

  assign din_beat = i_din;

  // ==============================
  // marker check
  // ==============================
  // with alignment on a pair is marker 1 then marker 0,
  // otherwise beats pair in arrival order
  assign pair_ok  = have_first_q & (~i_cfg.wa_en | (first_mrk_q & ~din_beat.marker));
  assign start_ok = ~i_cfg.wa_en | din_beat.marker;

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      have_first_q <= 1'b0;
      align_q      <= 1'b0;
    end
    else
    begin
      have_first_q <= ~pair_ok & start_ok;  // a repeated marker restarts the pair
      if (!i_cfg.wa_en)
        align_q <= 1'b0;
      else if (pair_ok)
        align_q <= 1'b1;
    end
  end

  always_ff @(posedge fs_fwd_clk)
  begin
    if (!pair_ok && start_ok)
    begin
      first_pld_q <= din_beat.payload;
      first_mrk_q <= din_beat.marker;
    end
  end

  assign word         = {din_beat.payload, first_pld_q};  // second beat on top
  assign o_align_done = align_q;

  aib_adapt_phcomp_dly #(.payload_t(logic [WORD_W-1:0])) u_rx_dly (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_dly                   (i_cfg.rx_dly),
    .i_vld                   (pair_ok),
    .i_data                  (word),
    .o_vld                   (o_rx_valid),
    .o_data                  (o_data_out)
  );

endmodule

`default_nettype wire

//--- verilog/aib_adapt_sr_ms.sv
// ==============================
// master sideband shift register
// ==============================
`default_nettype none

module aib_adapt_sr_ms (
  input  wire                              fs_fwd_clk,
  input  wire                              adpt_rstn_sync_fsfwdclk,
  input  wire  [aib_adapt_pkg::SB_LEN-1:0] i_sb_tx_word,
  output logic [aib_adapt_pkg::SB_LEN-1:0] o_sb_rx_word,
  output logic                             o_std_out,
  output logic                             o_stl_out,
  input  wire                              i_srd,
  input  wire                              i_srl,
  output logic                             o_ms_tx_transfer_en,
  output logic                             o_ms_rx_transfer_en
);
  import aib_adapt_pkg::*;

  logic [SB_CNT_W-1:0] tx_cnt_q;
  logic [SB_LEN-1:0]   tx_sr_q;
  logic                stl_q;
  logic [SB_CNT_W-1:0] rx_cnt_q;    // bits captured so far
  logic                rx_act_q;
  logic [SB_LEN-2:0]   rx_sr_q;
  logic [SB_LEN-1:0]   rx_word_q;
  logic                frame_end;

  // ==============================
  // serializer
  // ==============================
  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      tx_cnt_q <= SB_CNT_W'(SB_LEN - 1);  // load on first edge
      tx_sr_q  <= '0;
      stl_q    <= 1'b0;
    end
    else if (tx_cnt_q == SB_CNT_W'(SB_LEN - 1))
    begin
      tx_cnt_q <= '0;
      tx_sr_q  <= i_sb_tx_word;
      stl_q    <= 1'b1;
    end
    else
    begin
      tx_cnt_q <= tx_cnt_q + 1'b1;
      tx_sr_q  <= {tx_sr_q[SB_LEN-2:0], 1'b0};
      stl_q    <= 1'b0;
    end
  end

  assign o_std_out = tx_sr_q[SB_LEN-1];  // msb first
  assign o_stl_out = stl_q;

  // ==============================
  // deserializer
  // ==============================
  assign frame_end = rx_act_q & (rx_cnt_q == SB_CNT_W'(SB_LEN - 1));

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      rx_act_q  <= 1'b0;
      rx_cnt_q  <= '0;
      rx_word_q <= '0;
    end
    else if (i_srl)
    begin
      rx_act_q <= 1'b1;  // bit 80 arrives with srl
      rx_cnt_q <= SB_CNT_W'(1);
    end
    else if (rx_act_q)
    begin
      rx_cnt_q <= rx_cnt_q + 1'b1;
      if (frame_end)
      begin
        rx_act_q  <= 1'b0;
        rx_word_q <= {rx_sr_q, i_srd};
      end
    end
  end

  always_ff @(posedge fs_fwd_clk)
  begin
    rx_sr_q <= {rx_sr_q[SB_LEN-3:0], i_srd};
  end

  assign o_sb_rx_word        = rx_word_q;
  assign o_ms_tx_transfer_en = rx_word_q[SB_TX_EN_BIT];
  assign o_ms_rx_transfer_en = rx_word_q[SB_RX_EN_BIT];

endmodule

`default_nettype wire

//--- verilog/aib_adapt.sv
// ==============================
// aib adapter channel top
// ==============================
`default_nettype none

module aib_adapt (
  input  wire                                  fs_fwd_clk,
  input  wire                                  adpt_rstn_sync_fsfwdclk,
  input  wire aib_adapt_pkg::cfg_req_t         i_cfg_req,
  output wire aib_adapt_pkg::cfg_rsp_t         o_cfg_rsp,
  input  wire [aib_adapt_pkg::WORD_W-1:0]      i_data_in,     // from mac
  input  wire                                  i_tx_valid,
  output wire                                  o_tx_ready,
  output wire [aib_adapt_pkg::BEAT_W-1:0]      o_dout,        // to io buffer
  input  wire [aib_adapt_pkg::BEAT_W-1:0]      i_din,         // from io buffer
  output wire [aib_adapt_pkg::WORD_W-1:0]      o_data_out,    // to mac
  output wire                                  o_rx_valid,
  output wire                                  o_align_done,
  output wire                                  o_std_out,
  output wire                                  o_stl_out,
  input  wire                                  i_srd,
  input  wire                                  i_srl,
  output wire                                  o_ms_tx_transfer_en,
  output wire                                  o_ms_rx_transfer_en,
  output wire [aib_adapt_pkg::SB_LEN-1:0]      o_ms_sideband
);
  import aib_adapt_pkg::*;

  wire adapt_cfg_t        cfg;
  wire [SB_LEN-1:0]       sb_tx_word;

  aib_adapt_csr u_csr (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_cfg_req               (i_cfg_req),
    .o_cfg_rsp               (o_cfg_rsp),
    .o_cfg                   (cfg),
    .o_sb_tx_word            (sb_tx_word),
    .i_sb_rx_word            (o_ms_sideband)  // read back of received frame
  );

  aib_adapt_txchnl u_txchnl (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_cfg                   (cfg),
    .i_data_in               (i_data_in),
    .i_tx_valid              (i_tx_valid),
    .o_tx_ready              (o_tx_ready),
    .i_din                   (i_din),
    .o_dout                  (o_dout)
  );

  aib_adapt_rxchnl u_rxchnl (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_cfg                   (cfg),
    .i_din                   (i_din),
    .o_data_out              (o_data_out),
    .o_rx_valid              (o_rx_valid),
    .o_align_done            (o_align_done)
  );

  aib_adapt_sr_ms u_sr_ms (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_sb_tx_word            (sb_tx_word),
    .o_sb_rx_word            (o_ms_sideband),
    .o_std_out               (o_std_out),
    .o_stl_out               (o_stl_out),
    .i_srd                   (i_srd),
    .i_srl                   (i_srl),
    .o_ms_tx_transfer_en     (o_ms_tx_transfer_en),
    .o_ms_rx_transfer_en     (o_ms_rx_transfer_en)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
// ==============================
// tb clock and reset
// ==============================
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES = 5;

  initial
  begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;  // 4 ns period
  end

  initial
  begin
    o_rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rstn <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/tb_aib_adapt.sv
// ==============================
// aib adapter testbench
// ==============================
`default_nettype none

module tb_aib_adapt;
  timeunit 1ns;
  timeprecision 100ps;
  import aib_adapt_pkg::*;

  localparam int    TMO       = 64;
  localparam int    SB_TMO    = 3 * SB_LEN + 16;  // three frames and some slack
  localparam string STIM_FILE = "tests/aib_adapt_stimulus.txt";

  wire                clk;
  wire                rstn;
  cfg_req_t           cfg_req;
  wire cfg_rsp_t      cfg_rsp;
  logic [WORD_W-1:0]  data_in;
  logic               tx_valid;
  wire                tx_ready;
  wire  [BEAT_W-1:0]  dout;
  logic [BEAT_W-1:0]  din;
  wire  [WORD_W-1:0]  data_out;
  wire                rx_valid;
  wire                align_done;
  wire                std_out;
  wire                stl_out;
  logic               srd = 1'b0;
  logic               srl = 1'b0;
  wire                tx_en;
  wire                rx_en;
  wire  [SB_LEN-1:0]  sideband;
  integer             seed = 50624;
  logic [BEAT_W-1:0]  dout_exp[$];
  logic [BEAT_W-1:0]  dout_got[$];
  logic [WORD_W-1:0]  rx_exp[$];
  logic [WORD_W-1:0]  rx_got[$];

  tb_clk_gen u_clk_gen (
    .o_clk  (clk),
    .o_rstn (rstn)
  );

  aib_adapt u_dut (
    .fs_fwd_clk              (clk),
    .adpt_rstn_sync_fsfwdclk (rstn),
    .i_cfg_req               (cfg_req),
    .o_cfg_rsp               (cfg_rsp),
    .i_data_in               (data_in),
    .i_tx_valid              (tx_valid),
    .o_tx_ready              (tx_ready),
    .o_dout                  (dout),
    .i_din                   (din),
    .o_data_out              (data_out),
    .o_rx_valid              (rx_valid),
    .o_align_done            (align_done),
    .o_std_out               (std_out),
    .o_stl_out               (stl_out),
    .i_srd                   (srd),
    .i_srl                   (srl),
    .o_ms_tx_transfer_en     (tx_en),
    .o_ms_rx_transfer_en     (rx_en),
    .o_ms_sideband           (sideband)
  );

  // sideband looped back to itself
  always @(posedge clk)
  begin
    srd <= std_out;
    srl <= stl_out;
  end

  // ==============================
  // monitors
  // ==============================
  always @(negedge clk)
  begin
    if (dout != '0)
      dout_got.push_back(dout);  // idle beats are zero
    if (rx_valid)
      rx_got.push_back(data_out);
  end

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s at %0t ns", why, $time);
    $display("TESTBENCH FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic reset_state_check();
    int n;
    n = 0;
    @(negedge clk);
    while (!rstn)
    begin
      n++;
      if (n > TMO)
        abort_run("reset was never released");
      @(negedge clk);
    end
    check_value(tx_ready, 0, "o_tx_ready after reset");
    check_value(rx_valid, 0, "o_rx_valid after reset");
    check_value(align_done, 0, "o_align_done after reset");
    check_value(stl_out, 0, "o_stl_out after reset");
    check_value(tx_en, 0, "o_ms_tx_transfer_en after reset");
    check_value(rx_en, 0, "o_ms_rx_transfer_en after reset");
    check_value(cfg_rsp.waitreq, 1, "waitreq after reset");
    check_value(cfg_rsp.rdatavld, 0, "rdatavld after reset");
  endtask

  task automatic cfg_xfer(input logic wr, input logic [CFG_AW-1:0] addr,
                          input logic [CFG_DW-1:0] wdata, output logic [CFG_DW-1:0] rdata);
    int n;
    rdata = '0;
    @(posedge clk);
    cfg_req.read  <= ~wr;
    cfg_req.write <= wr;
    cfg_req.addr  <= addr;
    cfg_req.wdata <= wdata;
    n = 0;
    @(negedge clk);
    while (cfg_rsp.waitreq)
    begin
      n++;
      if (n > TMO)
        abort_run("config request was never accepted");
      @(negedge clk);
    end
    @(posedge clk);  // accepting edge
    cfg_req.read  <= 1'b0;
    cfg_req.write <= 1'b0;
    if (!wr)
    begin
      n = 0;
      @(negedge clk);
      while (!cfg_rsp.rdatavld)
      begin
        n++;
        if (n > TMO)
          abort_run("config read data never came back");
        @(negedge clk);
      end
      rdata = cfg_rsp.rdata;
    end
  endtask

  task automatic send_word(input logic [WORD_W-1:0] word);
    int n;
    @(posedge clk);
    data_in  <= word;
    tx_valid <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!tx_ready)
    begin
      n++;
      if (n > TMO)
        abort_run("mac word was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    tx_valid <= 1'b0;
  endtask

  task automatic drive_junk_beat();
    logic [63:0] rnd;
    beat_t       b;
    @(posedge clk);
    rx_got.delete();
    rnd = {$random(seed), $random(seed)};
    b = rnd[BEAT_W-1:0];
    b.marker = 1'b0;  // never a word start
    din <= b;
    @(negedge clk);
    check_value(align_done, 0, "o_align_done before first pair");
  endtask

  task automatic drive_pair(input logic [WORD_W-1:0] word);
    beat_t b;
    @(posedge clk);
    b.marker  = 1'b1;
    b.payload = word[PAYLOAD_W-1:0];
    din <= b;
    @(posedge clk);
    b.marker  = 1'b0;
    b.payload = word[WORD_W-1:PAYLOAD_W];
    din <= b;
  endtask

  task automatic collect_rx_words();
    int n;
    @(posedge clk);
    din <= '0;
    n = 0;
    @(negedge clk);
    while (rx_got.size() < rx_exp.size())
    begin
      n++;
      if (n > TMO)
        abort_run("receive words did not arrive");
      @(negedge clk);
    end
    check_value(align_done, 1, "o_align_done after pairs");
    @(posedge clk);
    check_value(rx_got.size(), rx_exp.size(), "receive word count");
    foreach (rx_exp[i])
      check_value(rx_got[i], rx_exp[i], $sformatf("o_data_out word %0d", i));
    rx_got.delete();
    rx_exp.delete();
  endtask

  task automatic drain_dout();
    int n;
    n = 0;
    @(negedge clk);
    while (dout_got.size() < dout_exp.size())
    begin
      n++;
      if (n > TMO)
        abort_run("beats on o_dout did not arrive");
      @(negedge clk);
    end
    @(posedge clk);
    check_value(dout_got.size(), dout_exp.size(), "o_dout beat count");
    foreach (dout_exp[i])
      check_value(dout_got[i], dout_exp[i], $sformatf("o_dout beat %0d", i));
    dout_got.delete();
    dout_exp.delete();
  endtask

  task automatic run_loopback(input int count);
    logic [63:0]       rnd;
    logic [BEAT_W-1:0] beat;
    @(posedge clk);
    tx_valid <= 1'b1;  // pending mac word must be refused
    for (int i = 0; i < count; i++)
    begin
      rnd = {$random(seed), $random(seed)};
      beat = rnd[BEAT_W-1:0];
      beat[0] = 1'b1;
      din <= beat;
      dout_exp.push_back(beat);
      @(negedge clk);
      check_value(tx_ready, 0, "o_tx_ready in loopback");
      @(posedge clk);
    end
    din      <= '0;
    tx_valid <= 1'b0;
  endtask

  task automatic await_sideband(input logic [SB_LEN-1:0] word);
    int n;
    n = 0;
    @(negedge clk);
    while (sideband !== word)
    begin
      n++;
      if (n > SB_TMO)
        abort_run("sideband word did not arrive within three frames");
      @(negedge clk);
    end
    check_value(tx_en, word[SB_TX_EN_BIT], "o_ms_tx_transfer_en");
    check_value(rx_en, word[SB_RX_EN_BIT], "o_ms_rx_transfer_en");
  endtask

  task automatic run_command(input logic [31:0] cmd, input logic [127:0] arg,
                             input logic [127:0] exp);
    logic [CFG_DW-1:0] rdata;
    case (cmd)
      32'h1: cfg_xfer(1'b1, arg[CFG_AW-1:0], exp[CFG_DW-1:0], rdata);
      32'h2:
      begin
        cfg_xfer(1'b0, arg[CFG_AW-1:0], '0, rdata);
        check_value(rdata, exp[CFG_DW-1:0],
                    $sformatf("config register %0d", arg[CFG_AW-1:0]));
      end
      32'h3:
      begin
        send_word(arg[WORD_W-1:0]);
        dout_exp.push_back(exp[BEAT_W-1:0]);  // first beat
        dout_exp.push_back(exp[2*BEAT_W-1:BEAT_W]);
      end
      32'h4:
      begin
        drive_pair(arg[WORD_W-1:0]);
        rx_exp.push_back(exp[WORD_W-1:0]);
      end
      32'h5: drain_dout();
      32'h6: await_sideband(exp[SB_LEN-1:0]);
      32'h7: drive_junk_beat();
      32'h8: collect_rx_words();
      32'h9: run_loopback(int'(arg[15:0]));
      default: abort_run($sformatf("unknown stimulus command %0h", cmd));
    endcase
  endtask

  initial
  begin
    int           fd;
    int           n;
    int           cnt;
    string        line;
    logic [31:0]  cmd;
    logic [127:0] arg;
    logic [127:0] exp;
    cfg_req  = '0;
    data_in  = '0;
    tx_valid = 1'b0;
    din      = '0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      abort_run("cannot open the stimulus file");
    end
    else
    begin
      reset_state_check();
      while (!$feof(fd))
      begin
        cnt = $fgets(line, fd);
        if (cnt > 0 && line[0] != "#")
        begin
          n = $sscanf(line, "%h %h %h", cmd, arg, exp);
          if (n == 3)
            run_command(cmd, arg, exp);
        end
      end
      $fclose(fd);
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tests/aib_adapt_stimulus.txt
# columns: command, address or word, expected value (write data for command 1), all hex
# 1 cfg write, 2 cfg read, 3 mac word, 4 rx pair, 5 check dout, 6 sideband, 7 junk, 8 rx check, 9 loopback
2 0 0
2 1 0
2 2 0
2 3 0
2 4 0
2 5 0
2 6 0
2 7 0
1 0 fffffff5
2 0 5
1 1 e
2 1 e
1 2 89abcdef
1 3 01234567
1 4 ffffc4a5
2 2 89abcdef
2 3 01234567
2 4 1c4a5
6 0 1c4a50123456789abcdef
2 5 89abcdef
2 6 01234567
2 7 1c4a5
3 8123456789 00000000018123456789
3 157fffffffff 000000002affffffffff
3 3fffffffff8000000000 7fffffffff8000000000
5 0 0
7 0 0
4 2a5a5a5a5a5a5a5a5a5a 2a5a5a5a5a5a5a5a5a5a
4 0123456789abcdef0123 0123456789abcdef0123
4 3fffc0000000003ffff1 3fffc0000000003ffff1
8 0 0
1 1 7
2 1 7
9 c 0
5 0 0

//--- aib_adapt.f
verilog/aib_adapt_pkg.sv
verilog/aib_adapt_phcomp_dly.sv
verilog/aib_adapt_csr.sv
verilog/aib_adapt_txchnl.sv
verilog/aib_adapt_rxchnl.sv
verilog/aib_adapt_sr_ms.sv
verilog/aib_adapt.sv
tests/tb_clk_gen.sv
tests/tb_aib_adapt.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = tb_aib_adapt
FILELIST  = aib_adapt.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
